//--- verilog/window_config.svh
`ifndef WINDOW_CONFIG_SVH
`define WINDOW_CONFIG_SVH

// Sample and coefficient widths, coefficients are Q1.15
`define WIN_SAMPLE_W 16
`define WIN_COEF_W 16

// Window size limit is 2**WIN_MAX_LOG2 entries
`define WIN_MAX_LOG2 11

// Settings bus and readback
`define WIN_SET_ADDR_W 8
`define WIN_SET_DATA_W 32
`define WIN_SR_BASE 8'd32
`define WIN_SR_READBACK 8'd255
`define WIN_RB_SEL_W 3
`define WIN_RB_W 64
`define WIN_RB_BAD 64'h0BAD_C0DE_0BAD_C0DE

// Config stream word
`define WIN_CFG_W 32

`endif

//--- verilog/window_types_pkg.sv
`include "window_config.svh"

package window_types_pkg;

  ///////////////////////////////////////////////////////////////////////
  // Data path types
  ///////////////////////////////////////////////////////////////////////

  // Complex sample, I in the upper half as on the stream bus
  typedef struct packed {
    logic signed [`WIN_SAMPLE_W-1:0] i;
    logic signed [`WIN_SAMPLE_W-1:0] q;
  } sample_t;

  // Real window coefficient
  typedef logic signed [`WIN_COEF_W-1:0] coef_t;

  // Output beat, last marks the final sample of a window
  typedef struct packed {
    sample_t data;
    logic    last;
  } beat_t;

  ///////////////////////////////////////////////////////////////////////
  // Control types
  ///////////////////////////////////////////////////////////////////////

  // Position inside the window, also used as coefficient RAM address
  typedef logic [`WIN_MAX_LOG2-1:0] idx_t;

endpackage

//--- verilog/window_regs_pkg.sv
`include "window_config.svh"

package window_regs_pkg;

  ///////////////////////////////////////////////////////////////////////
  // Settings bus register map
  ///////////////////////////////////////////////////////////////////////

  // Writable setting addresses
  typedef enum logic [`WIN_SET_ADDR_W-1:0] {
    // Window length in samples, 1 to the maximum size
    SR_WINDOW_LEN = `WIN_SR_BASE,
    // Selects what the readback bus returns
    SR_READBACK   = `WIN_SR_READBACK
  } sr_addr_e;

  ///////////////////////////////////////////////////////////////////////
  // Readback selections
  ///////////////////////////////////////////////////////////////////////

  // Codes not listed here read back the bad-address pattern
  typedef enum logic [`WIN_RB_SEL_W-1:0] {
    RB_MAX_SIZE   = 3'd0,
    RB_WINDOW_LEN = 3'd1,
    // Coefficients written since the last config tlast
    RB_COEF_COUNT = 3'd2
  } rb_sel_e;

endpackage

//--- verilog/window_settings.sv
`timescale 1ns/10ps
`include "window_config.svh"

module window_settings (
  input  logic                         ce_clk,
  input  logic                         i_rst_n,
  input  logic                         i_set_stb,
  input  logic [`WIN_SET_ADDR_W-1:0]   i_set_addr,
  input  logic [`WIN_SET_DATA_W-1:0]   i_set_data,
  input  window_types_pkg::idx_t       i_coef_count,
  output window_types_pkg::idx_t       o_win_last,
  output logic                         o_restart,
  output logic [`WIN_RB_W-1:0]         o_rb_data
);

  localparam logic [`WIN_RB_W-1:0] RB_MAX = 1 << `WIN_MAX_LOG2;

  logic                         wr_len;
  logic                         wr_rb;
  logic [`WIN_RB_SEL_W-1:0]     rb_sel;
  logic [`WIN_MAX_LOG2:0]       win_len;

  // Address decode
  assign wr_len = i_set_stb && (i_set_addr == window_regs_pkg::SR_WINDOW_LEN);
  assign wr_rb  = i_set_stb && (i_set_addr == window_regs_pkg::SR_READBACK);

  ///////////////////////////////////////////////////////////////////////
  // Setting registers
  ///////////////////////////////////////////////////////////////////////

  // Length kept as last index, so 2048 wraps to all ones
  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      o_win_last <= '1;
      rb_sel     <= window_regs_pkg::RB_MAX_SIZE;
      o_restart  <= 1'b0;
    end else begin
      o_restart <= wr_len;
      if (wr_len) begin
        o_win_last <= i_set_data[`WIN_MAX_LOG2-1:0] - 1;
      end
      if (wr_rb) begin
        rb_sel <= i_set_data[`WIN_RB_SEL_W-1:0];
      end
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Readback mux
  ///////////////////////////////////////////////////////////////////////

  assign win_len = {1'b0, o_win_last} + 1;

  always_comb begin
    case (rb_sel)
      window_regs_pkg::RB_MAX_SIZE: begin
        o_rb_data = RB_MAX;
      end
      window_regs_pkg::RB_WINDOW_LEN: begin
        o_rb_data = {{(`WIN_RB_W - `WIN_MAX_LOG2 - 1){1'b0}}, win_len};
      end
      window_regs_pkg::RB_COEF_COUNT: begin
        o_rb_data = {{(`WIN_RB_W - `WIN_MAX_LOG2){1'b0}}, i_coef_count};
      end
      default: begin
        o_rb_data = `WIN_RB_BAD;
      end
    endcase
  end

  // Back-to-back length writes would merge two restarts into one
  assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    o_restart |=> !o_restart);

endmodule

//--- verilog/window_sample_pipe.sv
`timescale 1ns/10ps
`include "window_config.svh"

module window_sample_pipe (
  input  logic                        ce_clk,
  input  logic                        i_rst_n,
  input  window_types_pkg::sample_t   i_tdata,
  input  logic                        i_tvalid,
  input  logic                        i_out_ready,
  output logic                        o_tready,
  output logic                        o_advance,
  output logic                        o_take,
  output window_types_pkg::sample_t   o_s2_sample,
  output logic                        o_s2_valid
);

  window_types_pkg::sample_t   s1_sample;
  logic                        s1_valid;
  // Valid of the output register held in the multiplier
  logic                        s2_valid;

  ///////////////////////////////////////////////////////////////////////
  // Stall control
  ///////////////////////////////////////////////////////////////////////

  // Whole pipe moves together or not at all
  assign o_advance = !s2_valid || i_out_ready;
  assign o_tready  = o_advance;
  assign o_take    = i_tvalid && o_advance;

  // Stage 1 data
  always_ff @(posedge ce_clk) begin
    if (o_advance) begin
      s1_sample <= i_tdata;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else if (o_advance) begin
      s1_valid <= i_tvalid;
      s2_valid <= s1_valid;
    end
  end

  // Sample presented to the multiplier stage
  assign o_s2_sample = s1_sample;
  assign o_s2_valid  = s1_valid;

  // Upstream keeps an offered sample steady until the pipe takes it
  assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    (i_tvalid && !o_tready) |=> i_tvalid && $stable(i_tdata));

endmodule

//--- verilog/window_coef_seq.sv
`timescale 1ns/10ps
`include "window_config.svh"

module window_coef_seq (
  input  logic                        ce_clk,
  input  logic                        i_rst_n,
  input  logic [`WIN_CFG_W-1:0]       i_cfg_tdata,
  input  logic                        i_cfg_tlast,
  input  logic                        i_cfg_tvalid,
  input  logic                        i_take,
  input  logic                        i_advance,
  input  logic                        i_restart,
  input  window_types_pkg::idx_t      i_win_last,
  output window_types_pkg::coef_t     o_coef,
  output logic                        o_last,
  output window_types_pkg::idx_t      o_coef_count
);

  localparam int DEPTH = 1 << `WIN_MAX_LOG2;

  window_types_pkg::coef_t   coef_ram [DEPTH];
  window_types_pkg::idx_t    load_ptr;
  window_types_pkg::idx_t    idx;
  window_types_pkg::idx_t    cur_idx;
  window_types_pkg::idx_t    idx_inc;
  logic                      at_end;

  ///////////////////////////////////////////////////////////////////////
  // Config stream loader
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge ce_clk) begin
    if (i_cfg_tvalid) begin
      coef_ram[load_ptr] <= i_cfg_tdata[`WIN_COEF_W-1:0];
    end
  end

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      load_ptr <= '0;
    end else if (i_cfg_tvalid) begin
      if (i_cfg_tlast) begin
        load_ptr <= '0;
      end else begin
        load_ptr <= load_ptr + 1;
      end
    end
  end

  assign o_coef_count = load_ptr;

  ///////////////////////////////////////////////////////////////////////
  // Window index
  ///////////////////////////////////////////////////////////////////////

  // A pending restart already points the read at entry 0
  assign cur_idx = i_restart ? '0 : idx;
  assign idx_inc = cur_idx + 1;
  assign at_end  = (cur_idx == i_win_last);

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      idx <= '0;
    end else if (i_take) begin
      idx <= at_end ? '0 : idx_inc;
    end else if (i_restart) begin
      idx <= '0;
    end
  end

  // Coefficient read lines up with sample stage 1
  always_ff @(posedge ce_clk) begin
    if (i_advance) begin
      o_coef <= coef_ram[cur_idx];
    end
  end

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      o_last <= 1'b0;
    end else if (i_advance) begin
      o_last <= i_take && at_end;
    end
  end

  // More than DEPTH beats without tlast would overwrite entry 0
  assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    (i_cfg_tvalid && (load_ptr == '1)) |-> i_cfg_tlast);

  // Coefficients change only while no sample is entering
  assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    i_cfg_tvalid |-> !i_take);

endmodule

//--- verilog/window_mult.sv
`timescale 1ns/10ps
`include "window_config.svh"

module window_mult (
  input  logic                        ce_clk,
  input  logic                        i_rst_n,
  input  window_types_pkg::sample_t   i_sample,
  input  logic                        i_valid,
  input  window_types_pkg::coef_t     i_coef,
  input  logic                        i_last,
  input  logic                        i_advance,
  output window_types_pkg::beat_t     o_beat,
  output logic                        o_valid
);

  localparam int PROD_W  = `WIN_SAMPLE_W + `WIN_COEF_W;
  localparam int FRAC_W  = `WIN_COEF_W - 1;
  // Shifted sum still carries the overflow bits
  localparam int SCALE_W = PROD_W + 1 - FRAC_W;

  localparam logic signed [PROD_W:0]    HALF   = 1 <<< (FRAC_W - 1);
  localparam logic signed [SCALE_W-1:0] SAT_HI = (1 <<< (`WIN_SAMPLE_W - 1)) - 1;
  localparam logic signed [SCALE_W-1:0] SAT_LO = -(1 <<< (`WIN_SAMPLE_W - 1));

  window_types_pkg::beat_t   beat_nxt;

  ///////////////////////////////////////////////////////////////////////
  // Round half up, then clip to the sample range
  ///////////////////////////////////////////////////////////////////////

  function automatic logic signed [`WIN_SAMPLE_W-1:0] round_sat(
    input logic signed [`WIN_SAMPLE_W-1:0] x,
    input logic signed [`WIN_COEF_W-1:0]   c
  );
    logic signed [PROD_W-1:0]  prod;
    logic signed [PROD_W:0]    sum;
    logic signed [SCALE_W-1:0] scaled;
    prod   = x * c;
    sum    = {prod[PROD_W-1], prod} + HALF;
    // Same bits as sum >>> FRAC_W
    scaled = sum[PROD_W:FRAC_W];
    if (scaled > SAT_HI) begin
      round_sat = SAT_HI[`WIN_SAMPLE_W-1:0];
    end else if (scaled < SAT_LO) begin
      round_sat = SAT_LO[`WIN_SAMPLE_W-1:0];
    end else begin
      round_sat = scaled[`WIN_SAMPLE_W-1:0];
    end
  endfunction

  // I and Q share the coefficient
  always_comb begin
    beat_nxt.data.i = round_sat(i_sample.i, i_coef);
    beat_nxt.data.q = round_sat(i_sample.q, i_coef);
    beat_nxt.last   = i_last;
  end

  ///////////////////////////////////////////////////////////////////////
  // Output register
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge ce_clk) begin
    if (i_advance) begin
      o_beat <= beat_nxt;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else if (i_advance) begin
      o_valid <= i_valid;
    end
  end

endmodule

//--- verilog/window_block.sv
`timescale 1ns/10ps
`include "window_config.svh"

module window_block (
  input  logic                        ce_clk,
  input  logic                        i_rst_n,
  // Settings bus
  input  logic                        i_set_stb,
  input  logic [`WIN_SET_ADDR_W-1:0]  i_set_addr,
  input  logic [`WIN_SET_DATA_W-1:0]  i_set_data,
  output logic [`WIN_RB_W-1:0]        o_rb_data,
  // Coefficient config stream
  input  logic [`WIN_CFG_W-1:0]       i_cfg_tdata,
  input  logic                        i_cfg_tlast,
  input  logic                        i_cfg_tvalid,
  output logic                        o_cfg_tready,
  // Sample streams
  input  window_types_pkg::sample_t   i_tdata,
  input  logic                        i_tvalid,
  output logic                        o_tready,
  output window_types_pkg::sample_t   o_tdata,
  output logic                        o_tlast,
  output logic                        o_tvalid,
  input  logic                        i_tready
);

  window_types_pkg::idx_t      win_last;
  window_types_pkg::idx_t      coef_count;
  logic                        restart;
  logic                        advance;
  logic                        take;
  window_types_pkg::sample_t   s2_sample;
  logic                        s2_valid;
  window_types_pkg::coef_t     coef;
  logic                        coef_last;
  window_types_pkg::beat_t     beat;

  // Coefficient RAM write port never stalls
  assign o_cfg_tready = 1'b1;

  window_settings inst_settings (
    .ce_clk(ce_clk), .i_rst_n(i_rst_n),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_coef_count(coef_count),
    .o_win_last(win_last), .o_restart(restart), .o_rb_data(o_rb_data));

  ///////////////////////////////////////////////////////////////////////
  // Sample path and coefficient path run side by side
  ///////////////////////////////////////////////////////////////////////

  window_sample_pipe inst_sample_pipe (
    .ce_clk(ce_clk), .i_rst_n(i_rst_n),
    .i_tdata(i_tdata), .i_tvalid(i_tvalid), .i_out_ready(i_tready),
    .o_tready(o_tready), .o_advance(advance), .o_take(take),
    .o_s2_sample(s2_sample), .o_s2_valid(s2_valid));

  window_coef_seq inst_coef_seq (
    .ce_clk(ce_clk), .i_rst_n(i_rst_n),
    .i_cfg_tdata(i_cfg_tdata), .i_cfg_tlast(i_cfg_tlast), .i_cfg_tvalid(i_cfg_tvalid),
    .i_take(take), .i_advance(advance), .i_restart(restart), .i_win_last(win_last),
    .o_coef(coef), .o_last(coef_last), .o_coef_count(coef_count));

  window_mult inst_mult (
    .ce_clk(ce_clk), .i_rst_n(i_rst_n),
    .i_sample(s2_sample), .i_valid(s2_valid),
    .i_coef(coef), .i_last(coef_last), .i_advance(advance),
    .o_beat(beat), .o_valid(o_tvalid));

  assign o_tdata = beat.data;
  assign o_tlast = beat.last;

endmodule

//--- test/tb_window_block.sv
`timescale 1ns/10ps
`include "window_config.svh"

module tb_window_block;

  localparam int TIMEOUT = 200;
  localparam int SAT_MAX = (1 << (`WIN_SAMPLE_W - 1)) - 1;
  localparam int SAT_MIN = -(1 << (`WIN_SAMPLE_W - 1));

  logic                        ce_clk;
  logic                        i_rst_n;
  logic                        i_set_stb;
  logic [`WIN_SET_ADDR_W-1:0]  i_set_addr;
  logic [`WIN_SET_DATA_W-1:0]  i_set_data;
  logic [`WIN_RB_W-1:0]        o_rb_data;
  logic [`WIN_CFG_W-1:0]       i_cfg_tdata;
  logic                        i_cfg_tlast;
  logic                        i_cfg_tvalid;
  logic                        o_cfg_tready;
  window_types_pkg::sample_t   i_tdata;
  logic                        i_tvalid;
  logic                        o_tready;
  window_types_pkg::sample_t   o_tdata;
  logic                        o_tlast;
  logic                        o_tvalid;
  logic                        i_tready = 1'b1;

  // Model of the coefficient RAM and window index
  window_types_pkg::coef_t     coef_mem [1 << `WIN_MAX_LOG2];
  int                          load_ptr;
  int                          model_idx;
  int                          model_len;
  window_types_pkg::beat_t     exp_q [$];
  int                          stamp_q [$];
  int                          cycle = 0;
  logic                        check_latency;
  logic                        stall_mode;

  window_block i_dut (.*);

  always #2 ce_clk = ~ce_clk;

  always @(posedge ce_clk) begin
    cycle <= cycle + 1;
  end

  // Downstream ready, random only while stalls are enabled
  always @(negedge ce_clk) begin
    if (stall_mode) begin
      i_tready = ($urandom() % 4) != 0;
    end else begin
      i_tready = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and checks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Q1.15 multiply, round half up, clip
  function automatic logic signed [`WIN_SAMPLE_W-1:0] scale_lane(input int x, input int c);
    int acc;
    acc = (x * c + (1 << 14)) >>> 15;
    if (acc > SAT_MAX) begin
      acc = SAT_MAX;
    end else if (acc < SAT_MIN) begin
      acc = SAT_MIN;
    end
    return acc[`WIN_SAMPLE_W-1:0];
  endfunction

  function automatic window_types_pkg::sample_t ref_product(
    input window_types_pkg::sample_t s,
    input window_types_pkg::coef_t   c
  );
    window_types_pkg::sample_t r;
    r.i = scale_lane(s.i, c);
    r.q = scale_lane(s.q, c);
    return r;
  endfunction

  // Called on the edge that accepts s
  task automatic push_expected(input window_types_pkg::sample_t s);
    window_types_pkg::beat_t b;
    b.data = ref_product(s, coef_mem[model_idx[`WIN_MAX_LOG2-1:0]]);
    b.last = (model_idx == model_len - 1);
    exp_q.push_back(b);
    stamp_q.push_back(cycle);
    model_idx = b.last ? 0 : model_idx + 1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus drivers
  //////////////////////////////////////////////////////////////////////

  task automatic set_reg(input logic [`WIN_SET_ADDR_W-1:0] addr,
                         input logic [`WIN_SET_DATA_W-1:0] data);
    @(negedge ce_clk);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    @(negedge ce_clk);
    i_set_stb = 1'b0;
    if (addr == window_regs_pkg::SR_WINDOW_LEN) begin
      model_len = int'(data);
      model_idx = 0;
    end
  endtask

  task automatic check_readback(input logic [`WIN_RB_SEL_W-1:0] sel,
                                input logic [63:0] exp, input string what);
    set_reg(window_regs_pkg::SR_READBACK, {29'd0, sel});
    @(posedge ce_clk);
    check_value(what, o_rb_data, exp);
  endtask

  task automatic cfg_beat(input logic [`WIN_CFG_W-1:0] data, input logic last);
    @(negedge ce_clk);
    i_cfg_tdata  = data;
    i_cfg_tlast  = last;
    i_cfg_tvalid = 1'b1;
    coef_mem[load_ptr[`WIN_MAX_LOG2-1:0]] = data[`WIN_COEF_W-1:0];
    load_ptr = last ? 0 : load_ptr + 1;
    @(negedge ce_clk);
    i_cfg_tvalid = 1'b0;
    i_cfg_tlast  = 1'b0;
  endtask

  task automatic idle_input(input int cycles);
    repeat (cycles) begin
      @(negedge ce_clk);
      i_tvalid = 1'b0;
    end
  endtask

  task automatic send_sample(input window_types_pkg::sample_t s);
    int waited;
    waited = 0;
    @(negedge ce_clk);
    i_tdata  = s;
    i_tvalid = 1'b1;
    @(posedge ce_clk);
    while (!o_tready) begin
      waited++;
      if (waited > TIMEOUT) begin
        stop_run("Timed out waiting for the block to accept a sample");
      end
      @(posedge ce_clk);
    end
    push_expected(s);
  endtask

  task automatic stream_random(input int count, input logic gaps);
    window_types_pkg::sample_t s;
    for (int n = 0; n < count; n++) begin
      if (gaps && ($urandom() % 3 == 0)) begin
        idle_input(1 + int'($urandom() % 3));
      end
      s = $urandom();
      send_sample(s);
    end
    idle_input(1);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge ce_clk);
      waited++;
      if (waited > TIMEOUT) begin
        stop_run("Timed out waiting for the output stream to drain");
      end
    end
  endtask

  // Output monitor, one expected beat per handshake
  always @(posedge ce_clk) begin : compare_outputs
    window_types_pkg::beat_t exp_beat;
    int                      stamp;
    if (i_rst_n && o_tvalid && i_tready) begin
      if (exp_q.size() == 0) begin
        stop_run("An output beat arrived with no sample pending");
      end else begin
        exp_beat = exp_q.pop_front();
        stamp    = stamp_q.pop_front();
        check_value("o_tdata.i", 64'(o_tdata.i), 64'(exp_beat.data.i));
        check_value("o_tdata.q", 64'(o_tdata.q), 64'(exp_beat.data.q));
        check_value("o_tlast", 64'(o_tlast), 64'(exp_beat.last));
        if (check_latency) begin
          check_value("latency in cycles", 64'(cycle - stamp), 64'd2);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    window_types_pkg::sample_t s;
    void'($urandom(32'h9ea8_7b69));
    ce_clk        = 1'b0;
    i_rst_n       = 1'b0;
    i_set_stb     = 1'b0;
    i_set_addr    = '0;
    i_set_data    = '0;
    i_cfg_tdata   = '0;
    i_cfg_tlast   = 1'b0;
    i_cfg_tvalid  = 1'b0;
    i_tdata       = '0;
    i_tvalid      = 1'b0;
    load_ptr      = 0;
    model_idx     = 0;
    model_len     = 1 << `WIN_MAX_LOG2;
    check_latency = 1'b0;
    stall_mode    = 1'b0;
    repeat (4) @(posedge ce_clk);
    @(negedge ce_clk);
    i_rst_n = 1'b1;

    // Reset values and readback defaults
    @(posedge ce_clk);
    check_value("default readback", o_rb_data, 64'd2048);
    check_value("o_tvalid after reset", 64'(o_tvalid), 64'd0);
    check_value("o_tready after reset", 64'(o_tready), 64'd1);
    check_value("o_cfg_tready", 64'(o_cfg_tready), 64'd1);
    check_readback(3'd5, `WIN_RB_BAD, "undefined readback");

    // Coefficient load, counted partway and after tlast
    for (int n = 0; n < 5; n++) begin
      cfg_beat($urandom(), 1'b0);
    end
    check_readback(window_regs_pkg::RB_COEF_COUNT, 64'd5, "partial coef count");
    for (int n = 5; n < 16; n++) begin
      cfg_beat($urandom(), n == 15);
    end
    check_readback(window_regs_pkg::RB_COEF_COUNT, 64'd0, "coef count after tlast");
    set_reg(window_regs_pkg::SR_WINDOW_LEN, 32'd16);
    check_readback(window_regs_pkg::RB_WINDOW_LEN, 64'd16, "window length");

    // Free-running stream, three windows
    check_latency = 1'b1;
    stream_random(48, 1'b0);
    wait_drain();

    // Full-scale negative operands
    for (int n = 0; n < 16; n++) begin
      cfg_beat((n % 2 == 0) ? 32'h0000_8000 : $urandom(), n == 15);
    end
    for (int n = 0; n < 16; n++) begin
      s   = $urandom();
      s.i = 16'h8000;
      if (n % 4 == 0) begin
        s.q = 16'h7fff;
      end
      send_sample(s);
    end
    idle_input(1);
    wait_drain();
    check_latency = 1'b0;

    // Back-pressure and input gaps
    stall_mode = 1'b1;
    stream_random(100, 1'b1);
    wait_drain();
    stall_mode = 1'b0;

    // Length change between bursts restarts the index
    stream_random(10, 1'b0);
    wait_drain();
    set_reg(window_regs_pkg::SR_WINDOW_LEN, 32'd8);
    check_readback(window_regs_pkg::RB_WINDOW_LEN, 64'd8, "new window length");
    stream_random(20, 1'b0);
    wait_drain();

    if (exp_q.size() == 0) begin
      $display("test passed");
      $finish;
    end else begin
      stop_run($sformatf("%0d expected beats never came out", exp_q.size()));
    end
  end

endmodule

//--- sources.f
+incdir+verilog
verilog/window_types_pkg.sv
verilog/window_regs_pkg.sv
verilog/window_settings.sv
verilog/window_sample_pipe.sv
verilog/window_coef_seq.sv
verilog/window_mult.sv
verilog/window_block.sv
test/tb_window_block.sv

//--- Makefile
# Verilator build and run for the window block testbench

TOP := tb_window_block

.PHONY: all lint clean

# Build, run, then decide pass or fail from the log
all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "test passed" sim.log

obj_dir/V$(TOP): sources.f verilog/window_config.svh verilog/*.sv test/*.sv
	verilator --binary --timing --assert -Wno-fatal \
		-f sources.f --top-module $(TOP) -Mdir obj_dir

lint:
	verilator --lint-only --timing --assert -Wall \
		-f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
